//--- hw/cart_pkg.sv
package cart_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [23:0] snes_addr_t;
  typedef logic [23:0] rom_addr_t;  // bit 0 picks the byte lane

  // settled view of the SNES A and B buses
  typedef struct packed {
    snes_addr_t addr;
    byte_t      pa;
    byte_t      data;
  } snes_bus_t;

  typedef struct packed {
    logic read;         // filtered levels, active low except cpu_clk
    logic write;
    logic pawr;
    logic cpu_clk;
    logic romsel;
    logic rd_start;     // single cycle pulses
    logic wr_end;
    logic pawr_start;
    logic cycle_start;
    logic cycle_end;
  } snes_strobes_t;

  // MCU side request towards the ROM pins
  typedef struct packed {
    rom_addr_t addr;
    byte_t     wdata;
    logic      we;      // active low, same as the pin
    logic      active;  // MCU owns the ROM bus
  } rom_drive_t;

  typedef struct packed {
    logic  drive;
    byte_t value;
  } force_byte_t;

  localparam byte_t      inidisp_pa = 8'h00;  // $2100
  localparam logic [3:0] limit_off  = 4'hf;

endpackage

//--- hw/snes_delay_line.sv
module snes_delay_line #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 6
) (
  input  logic     CLK2,
  input  logic     reset,
  input  payload_t d,
  output payload_t q [depth]
);

  // stage 0 takes the pin, every later stage is one clock older
  always_ff @(posedge CLK2) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        q[i] <= '0;  // idle bus
      end
    end else begin
      q[0] <= d;
      for (int i = 1; i < depth; i++) begin
        q[i] <= q[i - 1];
      end
    end
  end

endmodule

//--- hw/snes_bus_sync.sv
module snes_bus_sync import cart_pkg::*; #(
  parameter int dead_timeout = 80000
) (
  input  logic          CLK2,
  input  logic          reset,
  input  snes_addr_t    snes_addr_in,
  input  byte_t         snes_pa_in,
  input  byte_t         snes_data_in,
  input  logic          snes_read_in,
  input  logic          snes_write_in,
  input  logic          snes_pawr_in,
  input  logic          snes_romsel_in,
  input  logic          snes_cpu_clk_in,
  output snes_bus_t     bus,
  output snes_strobes_t strb,
  output logic          snes_dead,
  output logic          revive
);

  localparam int addr_depth = 6;
  localparam int data_depth = 4;
  localparam int cnt_w      = $clog2(dead_timeout + 2);

  snes_addr_t addr_q [addr_depth];
  byte_t      pa_q   [addr_depth];
  byte_t      data_q [data_depth];

  logic [6:0] read_hist;
  logic [6:0] write_hist;
  logic [6:0] pawr_hist;
  logic [6:0] cpu_clk_hist;
  logic [6:0] romsel_hist;
  logic       cpu_2100;

  logic [cnt_w-1:0] still_cnt;

  snes_delay_line #(.payload_t(snes_addr_t), .depth(addr_depth)) addr_line (
    .CLK2  (CLK2),
    .reset (reset),
    .d     (snes_addr_in),
    .q     (addr_q)
  );

  snes_delay_line #(.payload_t(byte_t), .depth(addr_depth)) pa_line (
    .CLK2  (CLK2),
    .reset (reset),
    .d     (snes_pa_in),
    .q     (pa_q)
  );

  snes_delay_line #(.payload_t(byte_t), .depth(data_depth)) data_line (
    .CLK2  (CLK2),
    .reset (reset),
    .d     (snes_data_in),
    .q     (data_q)
  );

  //////////////////////////////
  // strobe histories, newest sample in bit 0
  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_hist    <= '1;
      write_hist   <= '1;
      pawr_hist    <= '1;
      cpu_clk_hist <= '0;
      romsel_hist  <= '1;
    end else begin
      read_hist    <= {read_hist[5:0], snes_read_in};
      write_hist   <= {write_hist[5:0], snes_write_in};
      pawr_hist    <= {pawr_hist[5:0], snes_pawr_in};
      cpu_clk_hist <= {cpu_clk_hist[5:0], snes_cpu_clk_in};
      romsel_hist  <= {romsel_hist[5:0], snes_romsel_in};
    end
  end

  // CPU writes to $2100 settle sooner than DMA ones
  assign cpu_2100 = ({bus.addr[22], bus.addr[15:0]} == 17'h02100);

  always_comb begin
    bus.addr = addr_q[addr_depth - 1] & addr_q[addr_depth - 2];
    bus.pa   = pa_q[addr_depth - 1] & pa_q[addr_depth - 2];
    bus.data = data_q[data_depth - 1] & data_q[data_depth - 2];

    strb.read    = read_hist[2] & read_hist[1];
    strb.write   = write_hist[2] & write_hist[1];
    strb.pawr    = pawr_hist[2] & pawr_hist[1];
    strb.cpu_clk = cpu_clk_hist[2] & cpu_clk_hist[1];
    strb.romsel  = romsel_hist[5] & romsel_hist[4];  // waits for the address

    strb.rd_start    = (read_hist[6:1] == 6'b111110);
    strb.wr_end      = (write_hist[6:1] == 6'b000001);
    strb.pawr_start  = (pawr_hist[6:1] == (cpu_2100 ? 6'b111000 : 6'b100000));
    strb.cycle_start = (cpu_clk_hist[6:1] == 6'b000001);
    strb.cycle_end   = (cpu_clk_hist[6:1] == 6'b111110);
  end

  //////////////////////////////
  // dead console detection
  always_ff @(posedge CLK2) begin
    if (reset) begin
      still_cnt <= '0;
      snes_dead <= 1'b1;
      revive    <= 1'b0;
    end else begin
      revive <= 1'b0;
      if (cpu_clk_hist[1]) begin
        still_cnt <= '0;
        snes_dead <= 1'b0;
        revive    <= snes_dead;  // clock is back after a dead spell
      end else begin
        if (still_cnt <= cnt_w'(dead_timeout)) begin
          still_cnt <= still_cnt + 1'b1;  // stops one past the timeout
        end
        if (still_cnt > cnt_w'(dead_timeout)) snes_dead <= 1'b1;
      end
    end
  end

endmodule

//--- hw/mcu_rom_sched.sv
module mcu_rom_sched import cart_pkg::*; #(
  parameter int rom_cycle_len = 6
) (
  input  logic          CLK2,
  input  logic          reset,
  input  snes_strobes_t strb,
  input  logic          snes_dead,
  input  logic          revive,
  input  rom_addr_t     mcu_addr,
  input  byte_t         mcu_wdata,
  input  logic          mcu_rrq,
  input  logic          mcu_wrq,
  input  logic [15:0]   rom_rdata,
  output logic          mcu_rdy,
  output byte_t         mcu_rdata,
  output rom_drive_t    drive
);

  localparam int delay_w = $clog2(rom_cycle_len + 2);

  typedef enum logic [2:0] {
    st_idle,
    st_rd_addr,
    st_rd_end,
    st_wr_addr,
    st_wr_end
  } state_t;

  state_t             state;
  logic [delay_w-1:0] delay;
  logic               rd_pend;
  logic               wr_pend;
  rom_addr_t          addr_r;
  byte_t              wdata_r;
  logic               free_slot;
  logic               access_end;

  assign free_slot  = strb.cycle_end | snes_dead;  // SNES not using the ROM
  assign access_end = (state == st_rd_end) || (state == st_wr_end);

  //////////////////////////////
  // request latch
  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (access_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq | mcu_wrq) addr_r <= mcu_addr;
    if (mcu_wrq) wdata_r <= mcu_wdata;
  end

  //////////////////////////////
  // access FSM
  always_ff @(posedge CLK2) begin
    if (reset) begin
      state <= st_idle;
      delay <= '0;
    end else if (revive) begin
      state <= st_idle;  // console woke up, pending request retried later
    end else begin
      case (state)
        st_idle: begin
          if (free_slot && rd_pend) begin
            state <= st_rd_addr;
            delay <= delay_w'(rom_cycle_len);
          end else if (free_slot && wr_pend) begin
            state <= st_wr_addr;
            delay <= delay_w'(rom_cycle_len);
          end
        end
        st_rd_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= st_rd_end;
        end
        st_wr_addr: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= st_wr_end;
        end
        default: state <= st_idle;  // end cycles
      endcase
    end
  end

  // last sample of the address phase is the one kept
  always_ff @(posedge CLK2) begin
    if (state == st_rd_addr) begin
      mcu_rdata <= addr_r[0] ? rom_rdata[7:0] : rom_rdata[15:8];
    end
  end

  always_comb begin
    drive.addr   = addr_r;
    drive.wdata  = wdata_r;
    drive.we     = ~(state == st_wr_addr);
    drive.active = (state == st_rd_addr) || (state == st_wr_addr);
  end

endmodule

//--- hw/bright_limit.sv
module bright_limit import cart_pkg::*; (
  input  logic          CLK2,
  input  logic          reset,
  input  snes_bus_t     bus,
  input  snes_strobes_t strb,
  input  logic [3:0]    bright_limit_val,
  output force_byte_t   force_byte
);

  logic  limit_on;
  logic  over_limit;
  logic  limit_hit;
  logic  force_pre;
  logic  drive_r;
  byte_t value_r;

  assign limit_on   = (bright_limit_val != limit_off);
  assign over_limit = (bus.data[3:0] > bright_limit_val);

  // INIDISP write that asks for more than allowed
  assign limit_hit = strb.pawr_start && (bus.pa == inidisp_pa) && limit_on && over_limit;

  //////////////////////////////
  // force-write window
  always_ff @(posedge CLK2) begin
    if (reset) begin
      force_pre <= 1'b0;
      drive_r   <= 1'b0;
    end else begin
      if (strb.cycle_end) begin
        force_pre <= 1'b0;
      end else if (limit_hit) begin
        force_pre <= 1'b1;
      end
      drive_r <= force_pre & ~strb.cycle_end;  // one cycle behind the decision
    end
  end

  // keep forced blank bit, brightness clipped to the limit
  always_ff @(posedge CLK2) begin
    if (limit_hit) value_r <= {bus.data[7], 3'b100, bright_limit_val};
  end

  always_comb begin
    force_byte.drive = drive_r;
    force_byte.value = value_r;
  end

endmodule

//--- hw/rom_bus_mux.sv
module rom_bus_mux import cart_pkg::*; (
  input  snes_bus_t     bus,
  input  snes_strobes_t strb,
  input  rom_drive_t    drive,
  input  force_byte_t   force_byte,
  input  rom_addr_t     rom_mask,
  input  logic [15:0]   rom_rdata,
  output rom_addr_t     rom_addr,
  output byte_t         rom_wdata,
  output logic          rom_wdata_oe,
  output logic          rom_we,
  output logic          rom_bhe,
  output logic          rom_ble,
  output byte_t         snes_data_out,
  output logic          snes_databus_oe,
  output logic          snes_databus_dir
);

  logic  snes_rom_wr;
  logic  snes_rom_rd;
  logic  mcu_wr;
  logic  force_on;
  byte_t rom_lane;

  //////////////////////////////
  // ROM side
  assign rom_addr = drive.active ? drive.addr : (bus.addr & rom_mask);
  assign rom_bhe  = rom_addr[0];
  assign rom_ble  = ~rom_addr[0];

  assign snes_rom_wr = ~strb.romsel & ~strb.write;
  assign snes_rom_rd = ~strb.romsel & ~strb.read;
  assign mcu_wr      = drive.active & ~drive.we;

  always_comb begin
    if (drive.active) begin
      rom_we = drive.we;
    end else if (snes_rom_wr && strb.cpu_clk) begin
      rom_we = 1'b0;  // SNES write to the ROM area
    end else begin
      rom_we = 1'b1;
    end
  end

  assign rom_wdata    = snes_rom_wr ? bus.data : drive.wdata;
  assign rom_wdata_oe = snes_rom_wr | mcu_wr;

  //////////////////////////////
  // SNES side
  assign rom_lane = rom_addr[0] ? rom_rdata[7:0] : rom_rdata[15:8];
  assign force_on = force_byte.drive & ~strb.pawr;  // limiter beats the ROM

  assign snes_data_out    = force_on ? force_byte.value : rom_lane;
  assign snes_databus_oe  = ~(force_on | snes_rom_rd);
  assign snes_databus_dir = force_on | snes_rom_rd;  // high, cart drives

endmodule

//--- hw/cart_top.sv
module cart_top import cart_pkg::*; #(
  parameter int rom_cycle_len = 6,
  parameter int dead_timeout  = 80000
) (
  input  logic        CLK2,
  input  logic        reset,
  // SNES pins
  input  snes_addr_t  snes_addr_in,
  input  byte_t       snes_pa_in,
  input  byte_t       snes_data_in,
  input  logic        snes_read_in,
  input  logic        snes_write_in,
  input  logic        snes_pawr_in,
  input  logic        snes_romsel_in,
  input  logic        snes_cpu_clk_in,
  output byte_t       snes_data_out,
  output logic        snes_databus_oe,
  output logic        snes_databus_dir,
  // ROM / PSRAM
  output rom_addr_t   rom_addr,
  input  logic [15:0] rom_rdata,
  output byte_t       rom_wdata,
  output logic        rom_wdata_oe,
  output logic        rom_we,
  output logic        rom_bhe,
  output logic        rom_ble,
  // MCU request port
  input  rom_addr_t   mcu_addr,
  input  byte_t       mcu_wdata,
  input  logic        mcu_rrq,
  input  logic        mcu_wrq,
  output logic        mcu_rdy,
  output byte_t       mcu_rdata,
  // config
  input  rom_addr_t   rom_mask,
  input  logic [3:0]  bright_limit_val
);

  snes_bus_t     bus;
  snes_strobes_t strb;
  logic          snes_dead;
  logic          revive;
  rom_drive_t    drive;
  force_byte_t   force_byte;

  snes_bus_sync #(.dead_timeout(dead_timeout)) bus_sync (
    .CLK2            (CLK2),
    .reset           (reset),
    .snes_addr_in    (snes_addr_in),
    .snes_pa_in      (snes_pa_in),
    .snes_data_in    (snes_data_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_pawr_in    (snes_pawr_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .bus             (bus),
    .strb            (strb),
    .snes_dead       (snes_dead),
    .revive          (revive)
  );

  mcu_rom_sched #(.rom_cycle_len(rom_cycle_len)) rom_sched (
    .CLK2      (CLK2),
    .reset     (reset),
    .strb      (strb),
    .snes_dead (snes_dead),
    .revive    (revive),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .mcu_rrq   (mcu_rrq),
    .mcu_wrq   (mcu_wrq),
    .rom_rdata (rom_rdata),
    .mcu_rdy   (mcu_rdy),
    .mcu_rdata (mcu_rdata),
    .drive     (drive)
  );

  bright_limit limiter (
    .CLK2             (CLK2),
    .reset            (reset),
    .bus              (bus),
    .strb             (strb),
    .bright_limit_val (bright_limit_val),
    .force_byte       (force_byte)
  );

  rom_bus_mux bus_mux (
    .bus              (bus),
    .strb             (strb),
    .drive            (drive),
    .force_byte       (force_byte),
    .rom_mask         (rom_mask),
    .rom_rdata        (rom_rdata),
    .rom_addr         (rom_addr),
    .rom_wdata        (rom_wdata),
    .rom_wdata_oe     (rom_wdata_oe),
    .rom_we           (rom_we),
    .rom_bhe          (rom_bhe),
    .rom_ble          (rom_ble),
    .snes_data_out    (snes_data_out),
    .snes_databus_oe  (snes_databus_oe),
    .snes_databus_dir (snes_databus_dir)
  );

endmodule

//--- tests/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// 16 bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  return {s[14:0], fb};
endfunction

// preload pattern, every address bit matters
function automatic logic [15:0] fill_word(input logic [11:0] idx);
  logic [15:0] w;
  w = {4'h0, idx} * 16'd40503;
  return w ^ 16'ha5c3;
endfunction

function automatic byte_t lane_byte(input logic [15:0] word, input logic a0);
  return a0 ? word[7:0] : word[15:8];  // even byte sits in the upper half
endfunction

function automatic logic [15:0] store_lane(input logic [15:0] word, input logic a0,
                                           input byte_t d);
  return a0 ? {word[15:8], d} : {d, word[7:0]};
endfunction

function automatic rom_addr_t masked_addr(input snes_addr_t a, input rom_addr_t mask);
  return a & mask;
endfunction

// INIDISP write brighter than the limit, limiter switched on
function automatic logic expect_force(input byte_t pa, input byte_t d, input logic [3:0] lim);
  return (pa == inidisp_pa) && (lim != limit_off) && (d[3:0] > lim);
endfunction

function automatic byte_t limited_byte(input byte_t d, input logic [3:0] lim);
  return {d[7], 3'b100, lim};
endfunction

`endif

//--- tests/tb_cart_top.sv
module tb_cart_top import cart_pkg::*; ();

  `include "tb_ref.svh"

  localparam int dead_cycles = 300;
  localparam int rdy_timeout = 200;
  localparam int rom_words   = 4096;

  logic        CLK2 = 1'b0;
  logic        reset;
  snes_addr_t  snes_addr_in;
  byte_t       snes_pa_in;
  byte_t       snes_data_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_pawr_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in = 1'b0;
  byte_t       snes_data_out;
  logic        snes_databus_oe;
  logic        snes_databus_dir;
  rom_addr_t   rom_addr;
  logic [15:0] rom_rdata;
  byte_t       rom_wdata;
  logic        rom_wdata_oe;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;
  rom_addr_t   mcu_addr;
  byte_t       mcu_wdata;
  logic        mcu_rrq;
  logic        mcu_wrq;
  logic        mcu_rdy;
  byte_t       mcu_rdata;
  rom_addr_t   rom_mask;
  logic [3:0]  bright_limit_val;

  logic [15:0] rom_mem [rom_words];
  logic [15:0] lfsr_state = 16'd77;
  logic        cpu_run    = 1'b0;
  logic        cpu_hold   = 1'b0;
  int          cpu_cnt    = 0;

  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  string       msg_q [$];
  event        check_ev;
  int          err_cnt   = 0;
  int          test_err  = 0;
  int          test_cnt  = 0;
  int          check_cnt = 0;

  cart_top #(.dead_timeout(dead_cycles)) uut (.*);

  always #10 CLK2 = ~CLK2;

  //////////////////////////////
  // ROM model with active low byte enables
  initial begin
    for (int i = 0; i < rom_words; i++) rom_mem[i] = fill_word(12'(i));
  end

  assign rom_rdata = rom_mem[rom_addr[12:1]];

  always @(posedge CLK2) begin
    if (!rom_we) begin
      if (!rom_bhe) rom_mem[rom_addr[12:1]][15:8] <= rom_wdata;
      if (!rom_ble) rom_mem[rom_addr[12:1]][7:0] <= rom_wdata;
    end
  end

  // SNES CPU clock runs 8 cycles high and 8 low
  always @(posedge CLK2) begin : cpu_clock_gen
    logic next_level;
    next_level = snes_cpu_clk_in;
    if (!cpu_run) begin
      next_level = cpu_hold;
      cpu_cnt = 0;
    end else if (cpu_cnt == 7) begin
      next_level = ~snes_cpu_clk_in;
      cpu_cnt = 0;
    end else begin
      cpu_cnt++;
    end
    #2;
    snes_cpu_clk_in = next_level;
  end

  //////////////////////////////
  // compare process
  always begin : compare
    logic [31:0] got;
    logic [31:0] exp;
    string       msg;
    @(check_ev);
    while (got_q.size() > 0) begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      msg = msg_q.pop_front();
      check_cnt++;
      assert (got === exp) else begin
        $display("[ERROR] %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        err_cnt++;
        test_err++;
      end
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic queue_check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    got_q.push_back(got);
    exp_q.push_back(exp);
    msg_q.push_back(msg);
    -> check_ev;
  endtask

  task automatic note_timeout(input string what);
    $display("%0t: timed out, %s", $time, what);
    err_cnt++;
    test_err++;
  endtask

  task automatic finish_test(input string name);
    #1;
    test_cnt++;
    $display("test %0d, %s: %0d errors", test_cnt, name, test_err);
    test_err = 0;
  endtask

  task automatic cycles(input int n);
    repeat (n) begin
      @(posedge CLK2);
      #2;
    end
  endtask

  task automatic wait_rdy();
    int n;
    n = 0;
    @(negedge CLK2);
    while (!mcu_rdy && n < rdy_timeout) begin
      @(negedge CLK2);
      n++;
    end
    if (!mcu_rdy) note_timeout("mcu_rdy never came back high");
  endtask

  task automatic wait_cpu_clk(input logic level);
    int n;
    n = 0;
    @(negedge CLK2);
    while (snes_cpu_clk_in !== level && n < 40) begin
      @(negedge CLK2);
      n++;
    end
    if (snes_cpu_clk_in !== level) note_timeout("the SNES CPU clock did not toggle");
  endtask

  // one cycle request strobe and mcu_rdy drops right behind it
  task automatic mcu_access(input logic wr, input rom_addr_t a, input byte_t d);
    cycles(1);
    mcu_addr  = a;
    mcu_wdata = d;
    mcu_rrq   = ~wr;
    mcu_wrq   = wr;
    cycles(1);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    @(negedge CLK2);
    queue_check(32'(mcu_rdy), 32'd0, "mcu_rdy low while the access is pending");
  endtask

  task automatic limit_case(input byte_t d, input logic [3:0] lim);
    logic  hit;
    logic  seen;
    logic  got_dir;
    byte_t got_val;
    hit     = expect_force(inidisp_pa, d, lim);
    seen    = 1'b0;
    got_dir = 1'b0;
    got_val = '0;
    cycles(1);
    snes_addr_in     = 24'h002100;
    snes_pa_in       = inidisp_pa;
    snes_data_in     = d;
    bright_limit_val = lim;
    cycles(8);
    snes_pawr_in = 1'b0;
    repeat (10) begin
      @(negedge CLK2);
      if (!snes_databus_oe && !seen) begin
        seen    = 1'b1;
        got_val = snes_data_out;
        got_dir = snes_databus_dir;
      end
    end
    cycles(1);
    snes_pawr_in = 1'b1;
    cpu_hold     = 1'b0;  // falling CPU clock ends the cycle
    cycles(4);
    cpu_hold = 1'b1;
    cycles(4);
    queue_check(32'(seen), 32'(hit), "databus drive on an INIDISP write");
    if (hit) begin
      queue_check(32'(got_val), 32'(limited_byte(d, lim)), "limited INIDISP value");
      queue_check(32'(got_dir), 32'd1, "databus direction during the forced write");
    end
  endtask

  task automatic snes_read_case(input snes_addr_t a);
    rom_addr_t m;
    byte_t     exp;
    int        n;
    m   = masked_addr(a, rom_mask);
    exp = lane_byte(rom_mem[m[12:1]], m[0]);
    cycles(1);
    snes_addr_in = a;
    cycles(8);  // address settles ahead of the strobes
    snes_romsel_in = 1'b0;
    snes_read_in   = 1'b0;
    n = 0;
    @(negedge CLK2);
    while (snes_databus_oe && n < 20) begin
      @(negedge CLK2);
      n++;
    end
    if (snes_databus_oe) begin
      note_timeout("snes_databus_oe stayed high during a SNES ROM read");
    end else begin
      queue_check(32'(rom_addr), 32'(m), "ROM address of a SNES read");
      queue_check(32'(snes_data_out), 32'(exp), "SNES read data");
    end
    cycles(1);
    snes_romsel_in = 1'b1;
    snes_read_in   = 1'b1;
    cycles(6);
  endtask

  //////////////////////////////
  // test sequence
  initial begin : run
    rom_addr_t   a;
    byte_t       d;
    byte_t       exp;
    logic [15:0] old_word;
    logic [3:0]  lim;
    logic        seen_fall;
    logic        early;
    int          n;

    reset            = 1'b1;
    snes_addr_in     = '0;
    snes_pa_in       = 8'hff;
    snes_data_in     = '0;
    snes_read_in     = 1'b1;
    snes_write_in    = 1'b1;
    snes_pawr_in     = 1'b1;
    snes_romsel_in   = 1'b1;
    mcu_addr         = '0;
    mcu_wdata        = '0;
    mcu_rrq          = 1'b0;
    mcu_wrq          = 1'b0;
    rom_mask         = 24'h001fff;
    bright_limit_val = limit_off;
    repeat (8) @(posedge CLK2);
    #2;
    reset = 1'b0;

    @(negedge CLK2);
    queue_check(32'(mcu_rdy), 32'd1, "mcu_rdy after reset");
    queue_check(32'(rom_we), 32'd1, "rom_we after reset");
    queue_check(32'(rom_wdata_oe), 32'd0, "rom_wdata_oe after reset");
    queue_check(32'(snes_databus_oe), 32'd1, "snes_databus_oe after reset");
    finish_test("reset values");

    cpu_run = 1'b1;  // one clock pulse wakes the console first
    wait_cpu_clk(1'b1);
    wait_cpu_clk(1'b0);
    cpu_run = 1'b0;
    cycles(dead_cycles + 20);  // clock held low past the dead timeout
    a        = rom_addr_t'(rand_bits(13));
    d        = byte_t'(rand_bits(8));
    old_word = rom_mem[a[12:1]];
    mcu_access(1'b1, a, d);
    wait_rdy();
    queue_check(32'(rom_mem[a[12:1]]), 32'(store_lane(old_word, a[0], d)),
                "ROM word after an MCU write");
    finish_test("MCU write, console dead");

    a   = rom_addr_t'(rand_bits(13));
    exp = lane_byte(rom_mem[a[12:1]], a[0]);
    mcu_access(1'b0, a, '0);
    wait_rdy();
    queue_check(32'(mcu_rdata), 32'(exp), "mcu_rdata after an MCU read");
    finish_test("MCU read, console dead");

    cpu_run = 1'b1;
    wait_cpu_clk(1'b1);
    wait_cpu_clk(1'b0);
    wait_cpu_clk(1'b1);  // revive pulse is long gone
    a         = rom_addr_t'(rand_bits(13));
    d         = byte_t'(rand_bits(8));
    old_word  = rom_mem[a[12:1]];
    seen_fall = 1'b0;
    early     = 1'b0;
    mcu_access(1'b1, a, d);
    n = 0;
    while (!mcu_rdy && n < rdy_timeout) begin
      @(negedge CLK2);
      if (!snes_cpu_clk_in) seen_fall = 1'b1;
      if (rom_wdata_oe && !seen_fall) early = 1'b1;
      n++;
    end
    if (!mcu_rdy) note_timeout("mcu_rdy never came back high with the CPU clock running");
    queue_check(32'(early), 32'd0, "MCU write before the SNES cycle end");
    queue_check(32'(rom_mem[a[12:1]]), 32'(store_lane(old_word, a[0], d)),
                "ROM word after a scheduled MCU write");
    wait_cpu_clk(1'b1);
    cpu_hold = 1'b1;
    cpu_run  = 1'b0;
    finish_test("MCU write in a free slot");

    lim      = 4'(rand_bits(3));
    d        = byte_t'(rand_bits(8));
    d[3:0]   = lim + 4'd1 + 4'(rand_bits(2));
    limit_case(d, lim);  // brighter than allowed
    lim      = 4'(rand_bits(3)) + 4'd4;
    d        = byte_t'(rand_bits(8));
    d[3:0]   = lim;
    limit_case(d, lim);
    d = byte_t'(rand_bits(8));
    limit_case(d, limit_off);
    finish_test("INIDISP brightness limit");

    repeat (4) snes_read_case(snes_addr_t'(rand_bits(24)));
    finish_test("SNES ROM read");

    #1;
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0 && check_cnt > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+tests
hw/cart_pkg.sv
hw/snes_delay_line.sv
hw/snes_bus_sync.sv
hw/mcu_rom_sched.sv
hw/bright_limit.sv
hw/rom_bus_mux.sv
hw/cart_top.sv
tests/tb_cart_top.sv
